// File: logic/bedrock_pkg.sv
//####################################################################
// BedRock style message types
// Command and response formats shared by the loader, the router and
// the targets of the host I/O complex
//####################################################################

package bedrock_pkg;

  // Byte address of a command
  typedef logic [31:0] addr_t;

  // One data word
  typedef logic [63:0] data_t;

  // Command source identifier
  typedef logic [1:0] lce_id_t;

  // Source ids of the processor port and the boot loader
  localparam lce_id_t proc_id   = 2'd0;
  localparam lce_id_t loader_id = 2'd2;

  typedef enum logic [0:0]
  {
    msg_op_read  = 1'b0,
    msg_op_write = 1'b1
  } msg_op_e;

  typedef struct packed
  {
    msg_op_e op;
    addr_t   addr;
    lce_id_t src_id;
  } io_header_t;

  // Used for commands and for responses
  // Write responses carry zero data
  typedef struct packed
  {
    io_header_t header;
    data_t      data;
  } io_msg_t;

endpackage

// File: logic/host_pkg.sv
//####################################################################
// Host address map and load records
// Region bases, host register offsets and the boot record format
//####################################################################

package host_pkg;

  // Address bits 31 to 28 pick the region
  localparam bedrock_pkg::addr_t host_base = 32'h1000_0000;
  localparam bedrock_pkg::addr_t mem_base  = 32'h8000_0000;

  // Offsets inside the host region
  localparam logic [7:0] trace_en_off = 8'h00;
  localparam logic [7:0] finish_off   = 8'h08;
  localparam logic [7:0] putchar_off  = 8'h10;

  // Trace enable bits
  typedef logic [7:0] trace_en_t;

  typedef enum logic [1:0]
  {
    nbf_op_write  = 2'd0,
    nbf_op_fence  = 2'd1,
    nbf_op_finish = 2'd2
  } nbf_op_e;

  // One load record
  typedef struct packed
  {
    nbf_op_e             op;
    bedrock_pkg::addr_t  addr;
    bedrock_pkg::data_t  data;
  } nbf_record_t;

endpackage

// File: logic/nbf_loader.sv
//####################################################################
// Boot loader
// Turns load records into memory write commands and tracks the one
// command in flight; fence and finish wait for it to retire
//####################################################################

`timescale 1ns/1ps

module nbf_loader
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  host_pkg::nbf_record_t  nbf_i,
  input  logic                   nbf_v_i,
  output logic                   nbf_ready_o,
  output bedrock_pkg::io_msg_t   cmd_o,
  output logic                   cmd_v_o,
  input  logic                   cmd_ready_i,
  input  bedrock_pkg::io_msg_t   resp_i,
  input  logic                   resp_v_i,
  output logic                   resp_ready_o,
  output logic                   done_o
);

  typedef enum logic [1:0]
  {
    loader_idle,
    loader_send,
    loader_wait,
    loader_done
  } loader_state_e;

  loader_state_e        state_r;
  loader_state_e        state_n;
  bedrock_pkg::io_msg_t cmd_r;
  logic                 finish_r;
  logic                 pending_r;
  logic                 done_r;
  logic                 rec_xfer;
  logic                 cmd_xfer;

  // Records are taken in idle and again after finish
  assign nbf_ready_o  = (state_r == loader_idle) || (state_r == loader_done);
  assign rec_xfer     = nbf_v_i & nbf_ready_o;
  assign cmd_v_o      = (state_r == loader_send);
  assign cmd_o        = cmd_r;
  assign cmd_xfer     = cmd_v_o & cmd_ready_i;
  assign resp_ready_o = 1'b1;
  assign done_o       = done_r;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      loader_idle, loader_done:
      begin
        if (rec_xfer)
          state_n = (nbf_i.op == host_pkg::nbf_op_write) ? loader_send : loader_wait;
      end
      loader_send:
      begin
        if (cmd_xfer)
          state_n = loader_idle;
      end
      loader_wait:
      begin
        // Fence and finish hold until the last write retires
        if (!pending_r)
          state_n = finish_r ? loader_done : loader_idle;
      end
      default:
        state_n = loader_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r   <= loader_idle;
      finish_r  <= 1'b0;
      pending_r <= 1'b0;
      done_r    <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (rec_xfer)
        finish_r <= (nbf_i.op == host_pkg::nbf_op_finish);
      if (cmd_xfer)
        pending_r <= 1'b1;
      else if (resp_v_i)
        pending_r <= 1'b0;
      if (state_r == loader_wait && !pending_r && finish_r)
        done_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rec_xfer && nbf_i.op == host_pkg::nbf_op_write)
    begin
      cmd_r.header.op     <= bedrock_pkg::msg_op_write;
      cmd_r.header.addr   <= nbf_i.addr;
      cmd_r.header.src_id <= bedrock_pkg::loader_id;
      cmd_r.data          <= nbf_i.data;
    end
  end

  // Router only answers commands this loader has issued
  a_resp_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_i |-> pending_r && resp_i.header.src_id == bedrock_pkg::loader_id);

endmodule

// File: logic/io_router.sv
//####################################################################
// I/O router
// Fixed priority pick between loader and processor, region decode,
// one command in flight and a registered response back to the source
//####################################################################

`timescale 1ns/1ps

module io_router
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  bedrock_pkg::io_msg_t  ldr_cmd_i,
  input  logic                  ldr_cmd_v_i,
  output logic                  ldr_cmd_ready_o,
  output bedrock_pkg::io_msg_t  ldr_resp_o,
  output logic                  ldr_resp_v_o,
  input  logic                  ldr_resp_ready_i,
  input  bedrock_pkg::io_msg_t  proc_cmd_i,
  input  logic                  proc_cmd_v_i,
  output logic                  proc_cmd_ready_o,
  output bedrock_pkg::io_msg_t  proc_resp_o,
  output logic                  proc_resp_v_o,
  input  logic                  proc_resp_ready_i,
  output logic                  host_req_o,
  output logic                  mem_req_o,
  output bedrock_pkg::io_msg_t  req_msg_o,
  input  bedrock_pkg::data_t    host_rdata_i,
  input  bedrock_pkg::data_t    mem_rdata_i
);

  typedef enum logic
  {
    router_idle,
    router_respond
  } router_state_e;

  router_state_e        state_r;
  bedrock_pkg::io_msg_t sel_msg;
  bedrock_pkg::io_msg_t resp_r;
  bedrock_pkg::data_t   rd_data;
  logic [3:0]           region;
  logic                 host_hit;
  logic                 mem_hit;
  logic                 accept;
  logic                 to_ldr;
  logic                 responding;
  logic                 resp_xfer;

  // Loader wins when both are valid
  assign ldr_cmd_ready_o  = (state_r == router_idle);
  assign proc_cmd_ready_o = (state_r == router_idle) & ~ldr_cmd_v_i;
  assign accept = (ldr_cmd_v_i & ldr_cmd_ready_o) | (proc_cmd_v_i & proc_cmd_ready_o);
  assign sel_msg = ldr_cmd_v_i ? ldr_cmd_i : proc_cmd_i;

  assign region   = sel_msg.header.addr[31:28];
  assign host_hit = (region == host_pkg::host_base[31:28]);
  assign mem_hit  = (region == host_pkg::mem_base[31:28]);

  // Unmapped commands reach no target
  assign host_req_o = accept & host_hit;
  assign mem_req_o  = accept & mem_hit;
  assign req_msg_o  = sel_msg;

  always_comb
  begin
    if (host_hit)
      rd_data = host_rdata_i;
    else if (mem_hit)
      rd_data = mem_rdata_i;
    else
      rd_data = '0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r.header <= sel_msg.header;
      resp_r.data   <= (sel_msg.header.op == bedrock_pkg::msg_op_read) ? rd_data : '0;
    end
  end

  // Steer by the source id of the held response
  assign responding    = (state_r == router_respond);
  assign to_ldr        = (resp_r.header.src_id == bedrock_pkg::loader_id);
  assign ldr_resp_o    = resp_r;
  assign proc_resp_o   = resp_r;
  assign ldr_resp_v_o  = responding & to_ldr;
  assign proc_resp_v_o = responding & ~to_ldr;
  assign resp_xfer = (ldr_resp_v_o & ldr_resp_ready_i) | (proc_resp_v_o & proc_resp_ready_i);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_r <= router_idle;
    else if (accept)
      state_r <= router_respond;
    else if (resp_xfer)
      state_r <= router_idle;
  end

  a_proc_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    proc_resp_v_o && !proc_resp_ready_i |=> proc_resp_v_o && $stable(proc_resp_o));

endmodule

// File: logic/host_regs.sv
//####################################################################
// Host register block
// Trace enable bits, sticky finish flag and a character output
//####################################################################

`timescale 1ns/1ps

module host_regs
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,
  input  bedrock_pkg::io_msg_t  req_msg_i,
  output bedrock_pkg::data_t    rdata_o,
  output host_pkg::trace_en_t   trace_en_o,
  output logic                  finish_o,
  output logic [7:0]            putchar_o,
  output logic                  putchar_v_o
);

  host_pkg::trace_en_t trace_en_r;
  logic                finish_r;
  logic                putchar_v_r;
  logic [7:0]          putchar_r;
  logic [7:0]          offset;
  logic                wr;

  assign offset = req_msg_i.header.addr[7:0];
  assign wr     = req_i & (req_msg_i.header.op == bedrock_pkg::msg_op_write);

  // Only trace_en reads back
  assign rdata_o = (offset == host_pkg::trace_en_off) ? bedrock_pkg::data_t'(trace_en_r) : '0;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      trace_en_r  <= '0;
      finish_r    <= 1'b0;
      putchar_v_r <= 1'b0;
    end
    else
    begin
      if (wr && offset == host_pkg::trace_en_off)
        trace_en_r <= req_msg_i.data[7:0];
      if (wr && offset == host_pkg::finish_off)
        finish_r <= 1'b1;
      putchar_v_r <= wr && (offset == host_pkg::putchar_off);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr && offset == host_pkg::putchar_off)
      putchar_r <= req_msg_i.data[7:0];
  end

  assign trace_en_o  = trace_en_r;
  assign finish_o    = finish_r;
  assign putchar_o   = putchar_r;
  assign putchar_v_o = putchar_v_r;

endmodule

// File: logic/mem_store.sv
//####################################################################
// Program memory
// Word array with combinational read; unwritten words read as zero
//####################################################################

`timescale 1ns/1ps

module mem_store
#(
  parameter int mem_words_p = 256
)
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,
  input  bedrock_pkg::io_msg_t  req_msg_i,
  output bedrock_pkg::data_t    rdata_o
);

  localparam int idx_w_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

  typedef logic [idx_w_lp-1:0] mem_idx_t;

  bedrock_pkg::data_t   mem_r [mem_words_p];
  logic [mem_words_p-1:0] valid_r;
  mem_idx_t             idx;
  logic                 wr;

  // Word index from address bit 3 up
  assign idx = req_msg_i.header.addr[3 +: idx_w_lp];
  assign wr  = req_i & (req_msg_i.header.op == bedrock_pkg::msg_op_write);

  always_ff @(posedge clk_i)
  begin
    if (wr)
      mem_r[idx] <= req_msg_i.data;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_r <= '0;
    else if (wr)
      valid_r[idx] <= 1'b1;
  end

  assign rdata_o = valid_r[idx] ? mem_r[idx] : '0;

  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i |-> int'(idx) < mem_words_p);

endmodule

// File: logic/io_host_top.sv
//####################################################################
// Host I/O complex top
// Boot loader and processor port share the router to the host
// registers and the program memory
//####################################################################

`timescale 1ns/1ps

module io_host_top
#(
  parameter int mem_words_p = 256
)
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  host_pkg::nbf_record_t  nbf_i,
  input  logic                   nbf_v_i,
  output logic                   nbf_ready_o,
  input  bedrock_pkg::io_msg_t   proc_cmd_i,
  input  logic                   proc_cmd_v_i,
  output logic                   proc_cmd_ready_o,
  output bedrock_pkg::io_msg_t   proc_resp_o,
  output logic                   proc_resp_v_o,
  input  logic                   proc_resp_ready_i,
  output host_pkg::trace_en_t    trace_en_o,
  output logic                   finish_o,
  output logic [7:0]             putchar_o,
  output logic                   putchar_v_o,
  output logic                   load_done_o
);

  bedrock_pkg::io_msg_t ldr_cmd;
  logic                 ldr_cmd_v;
  logic                 ldr_cmd_ready;
  bedrock_pkg::io_msg_t ldr_resp;
  logic                 ldr_resp_v;
  logic                 ldr_resp_ready;
  bedrock_pkg::io_msg_t req_msg;
  logic                 host_req;
  logic                 mem_req;
  bedrock_pkg::data_t   host_rdata;
  bedrock_pkg::data_t   mem_rdata;

  nbf_loader loader0
  (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .nbf_i        (nbf_i),
    .nbf_v_i      (nbf_v_i),
    .nbf_ready_o  (nbf_ready_o),
    .cmd_o        (ldr_cmd),
    .cmd_v_o      (ldr_cmd_v),
    .cmd_ready_i  (ldr_cmd_ready),
    .resp_i       (ldr_resp),
    .resp_v_i     (ldr_resp_v),
    .resp_ready_o (ldr_resp_ready),
    .done_o       (load_done_o)
  );

  io_router router0
  (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .ldr_cmd_i         (ldr_cmd),
    .ldr_cmd_v_i       (ldr_cmd_v),
    .ldr_cmd_ready_o   (ldr_cmd_ready),
    .ldr_resp_o        (ldr_resp),
    .ldr_resp_v_o      (ldr_resp_v),
    .ldr_resp_ready_i  (ldr_resp_ready),
    .proc_cmd_i        (proc_cmd_i),
    .proc_cmd_v_i      (proc_cmd_v_i),
    .proc_cmd_ready_o  (proc_cmd_ready_o),
    .proc_resp_o       (proc_resp_o),
    .proc_resp_v_o     (proc_resp_v_o),
    .proc_resp_ready_i (proc_resp_ready_i),
    .host_req_o        (host_req),
    .mem_req_o         (mem_req),
    .req_msg_o         (req_msg),
    .host_rdata_i      (host_rdata),
    .mem_rdata_i       (mem_rdata)
  );

  host_regs regs0
  (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (host_req),
    .req_msg_i   (req_msg),
    .rdata_o     (host_rdata),
    .trace_en_o  (trace_en_o),
    .finish_o    (finish_o),
    .putchar_o   (putchar_o),
    .putchar_v_o (putchar_v_o)
  );

  mem_store #(.mem_words_p(mem_words_p)) mem0
  (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (mem_req),
    .req_msg_i (req_msg),
    .rdata_o   (mem_rdata)
  );

endmodule

// File: include/io_host_tb_table.svh
//####################################################################
// Host I/O complex test table
// One row per load record or processor command, with the expected
// response word and the output checked once the row is done
//####################################################################

`ifndef IO_HOST_TB_TABLE_SVH
`define IO_HOST_TB_TABLE_SVH

// Output checked after a row
typedef enum logic [2:0]
{
  side_none,
  side_trace,
  side_putchar,
  side_done,
  side_finish
} side_e;

typedef struct packed
{
  logic                  proc;
  host_pkg::nbf_record_t rec;
  bedrock_pkg::io_msg_t  cmd;
  bedrock_pkg::data_t    exp_resp;
  side_e                 side;
  bedrock_pkg::data_t    exp_side;
  logic [3:0]            hold;
} tb_row_t;

tb_row_t rows[$];
string   names[$];

task automatic build_table();
  bedrock_pkg::data_t d0;
  bedrock_pkg::data_t d1;
  bedrock_pkg::data_t d2;
  bedrock_pkg::data_t d3;
  bedrock_pkg::data_t d4;
  d0 = random_word();
  d1 = random_word();
  d2 = random_word();
  d3 = random_word();
  d4 = random_word();
  // Boot image, then a fence
  add_load("load word 0", host_pkg::nbf_op_write, 32'h8000_0000, d0, side_none, '0);
  add_load("load word 1", host_pkg::nbf_op_write, 32'h8000_0008, d1, side_none, '0);
  add_load("load word 3", host_pkg::nbf_op_write, 32'h8000_0018, d2, side_none, '0);
  add_load("load fence", host_pkg::nbf_op_fence, '0, '0, side_done, 64'd0);
  add_proc("read word 0", bedrock_pkg::msg_op_read, 32'h8000_0000, '0, d0, side_none, '0, 0);
  add_proc("read word 1", bedrock_pkg::msg_op_read, 32'h8000_0008, '0, d1, side_none, '0, 0);
  add_proc("read word 3", bedrock_pkg::msg_op_read, 32'h8000_0018, '0, d2, side_none, '0, 0);
  add_proc("read unwritten", bedrock_pkg::msg_op_read, 32'h8000_0010, '0, '0, side_none, '0, 0);
  add_proc("write trace_en", bedrock_pkg::msg_op_write, 32'h1000_0000, 64'hA5, '0,
           side_trace, 64'hA5, 0);
  add_proc("read trace_en", bedrock_pkg::msg_op_read, 32'h1000_0000, '0, 64'hA5,
           side_none, '0, 0);
  add_proc("write putchar", bedrock_pkg::msg_op_write, 32'h1000_0010, d3, '0,
           side_putchar, {56'd0, d3[7:0]}, 0);
  add_load("load word 4", host_pkg::nbf_op_write, 32'h8000_0020, d4, side_none, '0);
  add_load("load finish", host_pkg::nbf_op_finish, '0, '0, side_done, 64'd1);
  add_proc("read word 4", bedrock_pkg::msg_op_read, 32'h8000_0020, '0, d4, side_none, '0, 0);
  add_proc("write finish", bedrock_pkg::msg_op_write, 32'h1000_0008, 64'd1, '0,
           side_finish, 64'd1, 0);
  add_proc("read unmapped", bedrock_pkg::msg_op_read, 32'h4000_0000, '0, '0, side_none, '0, 0);
  add_proc("reread word 1", bedrock_pkg::msg_op_read, 32'h8000_0008, '0, d1, side_none, '0, 0);
  add_proc("held response", bedrock_pkg::msg_op_read, 32'h8000_0000, '0, d0, side_none, '0, 5);
  add_proc("read finish", bedrock_pkg::msg_op_read, 32'h1000_0008, '0, '0, side_none, '0, 0);
endtask

`endif

// File: dv/io_host_tb.sv
//####################################################################
// Host I/O complex testbench
// Applies the table of load records and processor commands to the
// top level and checks responses and host outputs
//####################################################################

`timescale 1ns/1ps

module io_host_tb;

  localparam int mem_words_lp = 256;

  logic                  clk_i = 1'b0;
  logic                  arst_n_i;
  host_pkg::nbf_record_t nbf_i;
  logic                  nbf_v_i;
  logic                  nbf_ready_o;
  bedrock_pkg::io_msg_t  proc_cmd_i;
  logic                  proc_cmd_v_i;
  logic                  proc_cmd_ready_o;
  bedrock_pkg::io_msg_t  proc_resp_o;
  logic                  proc_resp_v_o;
  logic                  proc_resp_ready_i;
  host_pkg::trace_en_t   trace_en_o;
  logic                  finish_o;
  logic [7:0]            putchar_o;
  logic                  putchar_v_o;
  logic                  load_done_o;

  integer seed = 32'h7b56;
  int     cycle_count = 0;
  int     cycle_limit = 0;
  int     putchar_pulses = 0;

  `include "io_host_tb_table.svh"

  io_host_top #(.mem_words_p(mem_words_lp)) dut0
  (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .nbf_i             (nbf_i),
    .nbf_v_i           (nbf_v_i),
    .nbf_ready_o       (nbf_ready_o),
    .proc_cmd_i        (proc_cmd_i),
    .proc_cmd_v_i      (proc_cmd_v_i),
    .proc_cmd_ready_o  (proc_cmd_ready_o),
    .proc_resp_o       (proc_resp_o),
    .proc_resp_v_o     (proc_resp_v_o),
    .proc_resp_ready_i (proc_resp_ready_i),
    .trace_en_o        (trace_en_o),
    .finish_o          (finish_o),
    .putchar_o         (putchar_o),
    .putchar_v_o       (putchar_v_o),
    .load_done_o       (load_done_o)
  );

  always #10 clk_i = ~clk_i;

  always @(negedge clk_i)
  begin
    if (putchar_v_o)
      putchar_pulses <= putchar_pulses + 1;
  end

  function automatic bedrock_pkg::data_t random_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic stop_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input bedrock_pkg::data_t exp,
                                 input bedrock_pkg::data_t got);
    $display("[FAIL] %s expected %h actual %h", name, exp, got);
    stop_run();
  endtask

  task automatic report_text(input string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_value(input string name, input bedrock_pkg::data_t exp,
                             input bedrock_pkg::data_t got);
    assert (got === exp) else report_mismatch(name, exp, got);
  endtask

  task automatic add_load(input string name, input host_pkg::nbf_op_e op,
                          input bedrock_pkg::addr_t addr, input bedrock_pkg::data_t data,
                          input side_e side, input bedrock_pkg::data_t exp_side);
    tb_row_t row;
    row          = '0;
    row.rec.op   = op;
    row.rec.addr = addr;
    row.rec.data = data;
    row.side     = side;
    row.exp_side = exp_side;
    rows.push_back(row);
    names.push_back(name);
  endtask

  task automatic add_proc(input string name, input bedrock_pkg::msg_op_e op,
                          input bedrock_pkg::addr_t addr, input bedrock_pkg::data_t data,
                          input bedrock_pkg::data_t exp_resp, input side_e side,
                          input bedrock_pkg::data_t exp_side, input int hold);
    tb_row_t row;
    row                   = '0;
    row.proc              = 1'b1;
    row.cmd.header.op     = op;
    row.cmd.header.addr   = addr;
    row.cmd.header.src_id = bedrock_pkg::proc_id;
    row.cmd.data          = data;
    row.exp_resp          = exp_resp;
    row.side              = side;
    row.exp_side          = exp_side;
    row.hold              = hold[3:0];
    rows.push_back(row);
    names.push_back(name);
  endtask

  // Record ends when the loader takes records again
  task automatic apply_load(input tb_row_t row);
    @(posedge clk_i);
    nbf_i   <= row.rec;
    nbf_v_i <= 1'b1;
    @(negedge clk_i);
    while (!nbf_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    nbf_v_i <= 1'b0;
    @(negedge clk_i);
    while (!nbf_ready_o)
      @(negedge clk_i);
  endtask

  task automatic apply_proc(input tb_row_t row, input string name);
    bedrock_pkg::io_msg_t held;
    @(posedge clk_i);
    proc_cmd_i        <= row.cmd;
    proc_cmd_v_i      <= 1'b1;
    proc_resp_ready_i <= (row.hold == 0);
    @(negedge clk_i);
    while (!proc_cmd_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    proc_cmd_v_i <= 1'b0;
    // Response is due in the cycle after acceptance
    @(negedge clk_i);
    assert (proc_resp_v_o === 1'b1)
    else report_text("Response missing in the cycle after the command was accepted");
    held = proc_resp_o;
    // Back-pressure window
    repeat (row.hold)
    begin
      assert (proc_resp_v_o === 1'b1)
      else report_text("Response valid dropped while the response port was stalled");
      assert (proc_resp_o === held)
      else report_text("Response payload changed while the response port was stalled");
      assert (proc_cmd_ready_o === 1'b0)
      else report_text("Command port became ready while a response was pending");
      @(negedge clk_i);
    end
    if (row.hold != 0)
    begin
      @(posedge clk_i);
      proc_resp_ready_i <= 1'b1;
      @(negedge clk_i);
      check_value({name, " valid"}, 64'd1, proc_resp_v_o);
    end
    check_value({name, " header"}, row.cmd.header, proc_resp_o.header);
    check_value({name, " data"}, row.exp_resp, proc_resp_o.data);
    @(posedge clk_i);
  endtask

  task automatic check_side(input tb_row_t row, input string name);
    @(negedge clk_i);
    case (row.side)
      side_trace:
        check_value({name, " trace_en"}, row.exp_side, trace_en_o);
      side_putchar:
      begin
        check_value({name, " putchar"}, row.exp_side, putchar_o);
        check_value({name, " pulses"}, 64'd1, putchar_pulses);
      end
      side_done:
        check_value({name, " load_done"}, row.exp_side, load_done_o);
      side_finish:
        check_value({name, " finish"}, row.exp_side, finish_o);
      default:
        ;
    endcase
  endtask

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit)
    begin
      $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
      stop_run();
    end
  end

  initial
  begin
    arst_n_i          = 1'b0;
    nbf_i             = '0;
    nbf_v_i           = 1'b0;
    proc_cmd_i        = '0;
    proc_cmd_v_i      = 1'b0;
    proc_resp_ready_i = 1'b1;
    build_table();
    cycle_limit = 40 * rows.size();
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("reset nbf_ready", 64'd1, nbf_ready_o);
    check_value("reset proc_cmd_ready", 64'd1, proc_cmd_ready_o);
    check_value("reset proc_resp_v", 64'd0, proc_resp_v_o);
    check_value("reset finish", 64'd0, finish_o);
    check_value("reset putchar_v", 64'd0, putchar_v_o);
    check_value("reset load_done", 64'd0, load_done_o);
    check_value("reset trace_en", 64'd0, trace_en_o);
    foreach (rows[i])
    begin
      if (rows[i].proc)
        apply_proc(rows[i], names[i]);
      else
        apply_load(rows[i]);
      check_side(rows[i], names[i]);
    end
    // Sticky flags and the single putchar pulse
    check_value("end load_done", 64'd1, load_done_o);
    check_value("end finish", 64'd1, finish_o);
    check_value("end putchar pulses", 64'd1, putchar_pulses);
    $display("No errors");
    $finish;
  end

endmodule

// File: src.f
+incdir+include
logic/bedrock_pkg.sv
logic/host_pkg.sv
logic/nbf_loader.sv
logic/io_router.sv
logic/host_regs.sv
logic/mem_store.sv
logic/io_host_top.sv
dv/io_host_tb.sv

// File: Bender.yml
package:
  name: io_host

sources:
  - logic/bedrock_pkg.sv
  - logic/host_pkg.sv
  - logic/nbf_loader.sv
  - logic/io_router.sv
  - logic/host_regs.sv
  - logic/mem_store.sv
  - logic/io_host_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/io_host_tb.sv
